// File: common/core_pkg.sv
`include "rs_settings.svh"

// types shared by the whole machine, not just the station
package core_pkg;

    // physical register tag as broadcast on the cdb
    typedef logic [`TAG_BITS-1:0] tag_t;

    // set of unresolved branches an instruction sits under
    typedef logic [`MASK_BITS-1:0] mask_t;

    // which execution unit kind takes the instruction
    typedef enum logic {
        fu_alu  = 1'b0,
        fu_mult = 1'b1
    } fu_t;

endpackage

// File: common/rs_pkg.sv
`include "rs_settings.svh"

// types private to the reservation station
package rs_pkg;

    // slot number inside the station
    typedef logic [$clog2(`RS_SIZE)-1:0] slot_idx_t;

    // one stored instruction
    typedef struct packed {
        logic                     valid;      // slot holds a live instruction
        core_pkg::tag_t           dest;       // result tag
        core_pkg::tag_t           src1;       // first source tag
        logic                     src1_used;
        logic                     src1_ready; // value produced or not needed
        core_pkg::tag_t           src2;       // second source tag
        logic                     src2_used;
        logic                     src2_ready;
        core_pkg::fu_t            fu;         // unit kind
        core_pkg::mask_t          mask;       // branches still unresolved
        logic [`PAYLOAD_BITS-1:0] payload;    // opaque op bits for the unit
    } entry_t;

endpackage

// File: common/rs_settings.svh
`ifndef RS_SETTINGS_SVH
`define RS_SETTINGS_SVH

// station geometry
`define RS_SIZE 8

// physical register tag width
`define TAG_BITS 6

// one bit per unresolved branch in flight
`define MASK_BITS 4

// opaque operation bits handed to the unit,
// the low MASK_BITS of them mirror the branch mask
`define PAYLOAD_BITS 16

`endif

// File: compile.f
+incdir+common
common/core_pkg.sv
common/rs_pkg.sv
design/reservation_station/rot_select.sv
design/reservation_station/rs_alloc.sv
design/reservation_station/rs_slot.sv
design/reservation_station/rs_issue.sv
design/reservation_station/rs_top.sv
sim/rs_checker.sv
sim/rs_tb.sv

// File: design/reservation_station/rot_select.sv
`timescale 1ns/100ps

// rotating priority selector, grants first req at or after ptr
module rot_select #(
    parameter int n = 8
) (
    input  logic         clock,
    input  logic         reset,
    input  logic [n-1:0] req,
    input  logic         advance,     // winner was taken, move past it
    output logic [n-1:0] gnt          // one-hot or zero
);

    localparam int ptr_bits = $clog2(n);

    logic [ptr_bits-1:0] ptr;         // highest priority position
    logic [ptr_bits-1:0] win;         // index of the granted req

    always_comb begin
        int   pos;
        logic found;
        gnt   = '0;
        win   = '0;
        found = 1'b0;
        pos   = 0;
        for (int j = 0; j < n; j++) begin
            pos = (int'(ptr) + j) % n;   // wrap around the request vector
            if (!found && req[pos]) begin
                gnt[pos] = 1'b1;
                win      = ptr_bits'(pos);
                found    = 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset)
            ptr <= '0;
        else if (advance && (|gnt))
            ptr <= (win == ptr_bits'(n - 1)) ? '0 : win + 1'b1;   // one past the winner
    end

endmodule

// File: design/reservation_station/rs_alloc.sv
`timescale 1ns/100ps
`include "rs_settings.svh"

// picks the slot a dispatch lands in, plus full/empty flags
module rs_alloc (
    input  logic                dispatch_valid,
    input  logic [`RS_SIZE-1:0] slot_busy,
    input  logic [`RS_SIZE-1:0] grant,       // slot leaving this cycle
    output logic [`RS_SIZE-1:0] alloc_we,
    output logic                full,
    output logic                empty
);

    rs_pkg::slot_idx_t   free_idx;   // lowest free slot
    logic [`RS_SIZE-1:0] pick;

    assign full  = &slot_busy;
    assign empty = ~|slot_busy;

    // scan from the top so the lowest free slot wins
    always_comb begin
        free_idx = '0;
        for (int i = `RS_SIZE - 1; i >= 0; i--) begin
            if (!slot_busy[i])
                free_idx = rs_pkg::slot_idx_t'(i);
        end
    end

    always_comb begin
        pick = '0;
        if (full)
            pick = grant;            // reuse the slot issuing now, zero if none
        else
            pick[free_idx] = 1'b1;
    end

    assign alloc_we = dispatch_valid ? pick : '0;

endmodule

// File: design/reservation_station/rs_issue.sv
`timescale 1ns/100ps
`include "rs_settings.svh"

// alu/mult arbitration and the issue register
module rs_issue (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [`RS_SIZE-1:0]           ready_alu,
    input  logic [`RS_SIZE-1:0]           ready_mult,
    input  rs_pkg::entry_t [`RS_SIZE-1:0] entries,
    input  logic                          alu_busy,
    input  logic                          branch_valid,
    input  core_pkg::mask_t               branch_mask,
    input  logic                          branch_squash,
    output logic [`RS_SIZE-1:0]           grant,
    output logic                          issue_valid,
    output core_pkg::fu_t                 issue_fu,
    output core_pkg::tag_t                issue_dest,
    output logic [`PAYLOAD_BITS-1:0]      issue_payload
);

    logic [`RS_SIZE-1:0]      alu_req;
    logic [`RS_SIZE-1:0]      alu_gnt;
    logic [`RS_SIZE-1:0]      mult_gnt;
    logic [`RS_SIZE-1:0]      sel_oh;         // one-hot chosen slot
    rs_pkg::slot_idx_t        sel_idx;
    rs_pkg::entry_t           sel_entry;
    logic                     take_alu;
    logic                     take_mult;
    logic                     fire;           // a selection goes out this cycle
    logic                     last_was_mult;
    logic [`PAYLOAD_BITS-1:0] payload_next;

    assign alu_req = ready_alu & {`RS_SIZE{~alu_busy}};   // alu held off while busy

    rot_select #(.n(`RS_SIZE)) i_alu_select (
        .clock   (clock),
        .reset   (reset),
        .req     (alu_req),
        .advance (fire & take_alu),
        .gnt     (alu_gnt)
    );

    rot_select #(.n(`RS_SIZE)) i_mult_select (
        .clock   (clock),
        .reset   (reset),
        .req     (ready_mult),
        .advance (fire & take_mult),
        .gnt     (mult_gnt)
    );

    // alu goes after a mult, or when no mult is waiting
    assign take_alu  = (|alu_gnt) & (last_was_mult | ~(|mult_gnt));
    assign take_mult = (|mult_gnt) & ~take_alu;
    assign sel_oh    = take_alu ? alu_gnt : (take_mult ? mult_gnt : '0);

    always_comb begin
        sel_idx = '0;
        for (int i = 0; i < `RS_SIZE; i++) begin
            if (sel_oh[i])
                sel_idx = rs_pkg::slot_idx_t'(i);
        end
    end

    assign sel_entry = entries[sel_idx];
    // a slot hit by a squash drops its own request
    assign fire      = take_alu | take_mult;
    assign grant     = fire ? sel_oh : '0;   // slot frees itself next edge

    // resolved branch bit cleared from the outgoing copy as well
    always_comb begin
        payload_next = sel_entry.payload;
        if (branch_valid && !branch_squash)
            payload_next[`MASK_BITS-1:0] = sel_entry.payload[`MASK_BITS-1:0] & ~branch_mask;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            issue_valid   <= 1'b0;
            last_was_mult <= 1'b0;
        end else begin
            issue_valid <= fire;
            if (fire)
                last_was_mult <= take_mult;   // held across idle cycles
        end
    end

    always_ff @(posedge clock) begin
        if (fire) begin
            issue_fu      <= sel_entry.fu;
            issue_dest    <= sel_entry.dest;
            issue_payload <= payload_next;
        end
    end

endmodule

// File: design/reservation_station/rs_slot.sv
`timescale 1ns/100ps
`include "rs_settings.svh"

// one station entry: capture, tag wakeup, branch mask upkeep, squash, free on grant
module rs_slot (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     write_enable,
    input  core_pkg::tag_t           dispatch_dest,
    input  core_pkg::tag_t           dispatch_src1,
    input  logic                     dispatch_src1_used,
    input  core_pkg::tag_t           dispatch_src2,
    input  logic                     dispatch_src2_used,
    input  core_pkg::fu_t            dispatch_fu,
    input  core_pkg::mask_t          dispatch_mask,
    input  logic [`PAYLOAD_BITS-1:0] dispatch_payload,
    input  logic                     cdb_valid,
    input  core_pkg::tag_t           cdb_tag,
    input  logic                     branch_valid,
    input  core_pkg::mask_t          branch_mask,
    input  logic                     branch_squash,
    input  logic                     grant,
    output logic                     busy,
    output logic                     ready_alu,
    output logic                     ready_mult,
    output rs_pkg::entry_t           entry
);

    rs_pkg::entry_t entry_q;
    logic           squash_hit;   // a squash kills this entry this cycle
    logic           resolve;      // a branch retires without squash
    logic           src1_wake;    // cdb matches a waiting source
    logic           src2_wake;
    logic           operands_ok;

    assign squash_hit = entry_q.valid & branch_valid & branch_squash
                      & (|(entry_q.mask & branch_mask));
    assign resolve    = branch_valid & ~branch_squash;
    assign src1_wake  = cdb_valid & entry_q.src1_used & (cdb_tag == entry_q.src1);
    assign src2_wake  = cdb_valid & entry_q.src2_used & (cdb_tag == entry_q.src2);

    always_ff @(posedge clock) begin
        if (reset) begin
            entry_q <= '0;
        end else if (write_enable) begin
            // dispatch wins over everything else in the cycle
            entry_q.valid      <= 1'b1;
            entry_q.dest       <= dispatch_dest;
            entry_q.src1       <= dispatch_src1;
            entry_q.src1_used  <= dispatch_src1_used;
            // unused source is ready, same-cycle broadcast is bypassed
            entry_q.src1_ready <= ~dispatch_src1_used | (cdb_valid & (cdb_tag == dispatch_src1));
            entry_q.src2       <= dispatch_src2;
            entry_q.src2_used  <= dispatch_src2_used;
            entry_q.src2_ready <= ~dispatch_src2_used | (cdb_valid & (cdb_tag == dispatch_src2));
            entry_q.fu         <= dispatch_fu;
            entry_q.mask       <= dispatch_mask;
            entry_q.payload    <= dispatch_payload;
        end else if (entry_q.valid) begin
            if (squash_hit || grant)
                entry_q.valid <= 1'b0;           // killed or handed to a unit
            if (src1_wake)
                entry_q.src1_ready <= 1'b1;
            if (src2_wake)
                entry_q.src2_ready <= 1'b1;
            if (resolve) begin
                entry_q.mask <= entry_q.mask & ~branch_mask;
                // keep the unit's copy of the mask in step
                entry_q.payload[`MASK_BITS-1:0] <=
                    entry_q.payload[`MASK_BITS-1:0] & ~branch_mask;
            end
        end
    end

    // request only when both sources are in and no squash hits us now
    assign operands_ok = entry_q.valid & entry_q.src1_ready & entry_q.src2_ready & ~squash_hit;
    assign ready_alu   = operands_ok & (entry_q.fu == core_pkg::fu_alu);
    assign ready_mult  = operands_ok & (entry_q.fu == core_pkg::fu_mult);

    assign busy  = entry_q.valid;
    assign entry = entry_q;

endmodule

// File: design/reservation_station/rs_top.sv
`timescale 1ns/100ps
`include "rs_settings.svh"

// reservation station top, allocator + slots + issue arbiter
module rs_top (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     dispatch_valid,
    input  core_pkg::tag_t           dispatch_dest,
    input  core_pkg::tag_t           dispatch_src1,
    input  logic                     dispatch_src1_used,
    input  core_pkg::tag_t           dispatch_src2,
    input  logic                     dispatch_src2_used,
    input  core_pkg::fu_t            dispatch_fu,
    input  core_pkg::mask_t          dispatch_mask,
    input  logic [`PAYLOAD_BITS-1:0] dispatch_payload,
    input  logic                     cdb_valid,
    input  core_pkg::tag_t           cdb_tag,
    input  logic                     branch_valid,
    input  core_pkg::mask_t          branch_mask,    // one-hot
    input  logic                     branch_squash,
    input  logic                     alu_busy,
    output logic                     issue_valid,
    output core_pkg::fu_t            issue_fu,
    output core_pkg::tag_t           issue_dest,
    output logic [`PAYLOAD_BITS-1:0] issue_payload,
    output logic                     full,
    output logic                     empty
);

    logic [`RS_SIZE-1:0]             slot_busy;  // per slot occupancy
    logic [`RS_SIZE-1:0]             alloc_we;   // one-hot write strobe
    logic [`RS_SIZE-1:0]             ready_alu;  // alu request per slot
    logic [`RS_SIZE-1:0]             ready_mult; // mult request per slot
    logic [`RS_SIZE-1:0]             grant;      // one-hot issue grant
    rs_pkg::entry_t [`RS_SIZE-1:0]   entries;    // slot contents to the arbiter

    rs_alloc i_rs_alloc (
        .dispatch_valid (dispatch_valid),
        .slot_busy      (slot_busy),
        .grant          (grant),
        .alloc_we       (alloc_we),
        .full           (full),
        .empty          (empty)
    );

    for (genvar i = 0; i < `RS_SIZE; i++) begin : g_slot
        rs_slot i_rs_slot (
            .clock              (clock),
            .reset              (reset),
            .write_enable       (alloc_we[i]),
            .dispatch_dest      (dispatch_dest),
            .dispatch_src1      (dispatch_src1),
            .dispatch_src1_used (dispatch_src1_used),
            .dispatch_src2      (dispatch_src2),
            .dispatch_src2_used (dispatch_src2_used),
            .dispatch_fu        (dispatch_fu),
            .dispatch_mask      (dispatch_mask),
            .dispatch_payload   (dispatch_payload),
            .cdb_valid          (cdb_valid),
            .cdb_tag            (cdb_tag),
            .branch_valid       (branch_valid),
            .branch_mask        (branch_mask),
            .branch_squash      (branch_squash),
            .grant              (grant[i]),
            .busy               (slot_busy[i]),
            .ready_alu          (ready_alu[i]),
            .ready_mult         (ready_mult[i]),
            .entry              (entries[i])
        );
    end

    rs_issue i_rs_issue (
        .clock         (clock),
        .reset         (reset),
        .ready_alu     (ready_alu),
        .ready_mult    (ready_mult),
        .entries       (entries),
        .alu_busy      (alu_busy),
        .branch_valid  (branch_valid),
        .branch_mask   (branch_mask),
        .branch_squash (branch_squash),
        .grant         (grant),
        .issue_valid   (issue_valid),
        .issue_fu      (issue_fu),
        .issue_dest    (issue_dest),
        .issue_payload (issue_payload)
    );

endmodule

// File: run.sh
#!/bin/sh
# build and run the reservation station testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module rs_tb -f compile.f -o rs_sim

out=$(./obj_dir/rs_sim)
echo "$out"

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

// File: sim/rs_checker.sv
`timescale 1ns/100ps
`include "rs_settings.svh"

// watches the station ports, keeps a model of pending instructions, compares issues
module rs_checker (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     dispatch_valid,
    input  core_pkg::tag_t           dispatch_dest,
    input  core_pkg::tag_t           dispatch_src1,
    input  logic                     dispatch_src1_used,
    input  core_pkg::tag_t           dispatch_src2,
    input  logic                     dispatch_src2_used,
    input  core_pkg::fu_t            dispatch_fu,
    input  core_pkg::mask_t          dispatch_mask,
    input  logic [`PAYLOAD_BITS-1:0] dispatch_payload,
    input  logic                     cdb_valid,
    input  core_pkg::tag_t           cdb_tag,
    input  logic                     branch_valid,
    input  core_pkg::mask_t          branch_mask,
    input  logic                     branch_squash,
    input  logic                     alu_busy,
    input  logic                     issue_valid,
    input  core_pkg::fu_t            issue_fu,
    input  core_pkg::tag_t           issue_dest,
    input  logic [`PAYLOAD_BITS-1:0] issue_payload,
    input  logic                     full,
    input  logic                     empty,
    output int                       pending,    // instructions still owed an issue
    output int                       errors,
    output int                       busy_mult   // mult issues picked while alu_busy
);

    localparam int not_ready = 32'h7fff_ffff;

    typedef struct packed {
        core_pkg::tag_t           dest;
        core_pkg::fu_t            fu;
        logic [`PAYLOAD_BITS-1:0] payload;     // expected, resolved bits cleared
        core_pkg::mask_t          mask;
        core_pkg::tag_t           src1;
        logic                     wait1;       // source still owed a broadcast
        core_pkg::tag_t           src2;
        logic                     wait2;
        int                       ready_cycle; // cycle the last source arrived
    } model_t;

    model_t model[$];
    int     cycle;
    logic   last_mult;   // previous issue went to the multiplier
    logic   alu_cand;    // an alu entry was selectable last cycle
    logic   busy_prev;   // alu_busy during the selection cycle

    task automatic log_error(input string msg);
        $display("ERROR %0t: %s", $time, msg);
        errors++;
    endtask

    // sampled mid-cycle, inputs and outputs are both settled here
    always @(negedge clock) begin
        int     hit;
        logic   found;
        logic   was_waiting;
        model_t e;
        if (reset) begin
            model.delete();
            cycle     = 0;
            last_mult = 1'b0;
            alu_cand  = 1'b0;
            busy_prev = 1'b0;
            errors    = 0;
            busy_mult = 0;
        end else begin
            if (issue_valid) begin
                found = 1'b0;
                hit   = 0;
                for (int i = 0; i < model.size(); i++) begin
                    if (!found && model[i].dest == issue_dest) begin
                        hit   = i;
                        found = 1'b1;
                    end
                end
                if (!found) begin
                    log_error($sformatf("issue of unknown or squashed dest %0d", issue_dest));
                end else begin
                    e = model[hit];
                    if (e.fu != issue_fu)
                        log_error($sformatf("dest %0d issued with wrong fu", issue_dest));
                    if (e.payload != issue_payload)
                        log_error($sformatf("dest %0d payload %h, expected %h",
                                            issue_dest, issue_payload, e.payload));
                    if (e.ready_cycle > cycle - 2)
                        log_error($sformatf("dest %0d issued before its sources", issue_dest));
                    model.delete(hit);
                end
                if (issue_fu == core_pkg::fu_alu && busy_prev)
                    log_error($sformatf("alu dest %0d issued under alu_busy", issue_dest));
                if (issue_fu == core_pkg::fu_mult && busy_prev)
                    busy_mult++;
                // alu must follow a mult when one was waiting
                if (issue_fu == core_pkg::fu_mult && last_mult && alu_cand && !busy_prev)
                    log_error($sformatf("mult dest %0d skipped a ready alu", issue_dest));
                last_mult = (issue_fu == core_pkg::fu_mult);
            end

            // occupancy seen by the slots this cycle
            if (full != (model.size() == `RS_SIZE))
                log_error($sformatf("full is %0b with %0d pending", full, model.size()));
            if (empty != (model.size() == 0))
                log_error($sformatf("empty is %0b with %0d pending", empty, model.size()));
            if (dispatch_valid && model.size() == `RS_SIZE)
                log_error("dispatch while full");

            alu_cand = 1'b0;
            foreach (model[i]) begin
                if (model[i].fu == core_pkg::fu_alu && model[i].ready_cycle < cycle
                    && !(branch_valid && branch_squash && |(model[i].mask & branch_mask)))
                    alu_cand = 1'b1;
            end
            busy_prev = alu_busy;

            if (cdb_valid) begin
                foreach (model[i]) begin
                    was_waiting = model[i].wait1 | model[i].wait2;
                    if (model[i].wait1 && model[i].src1 == cdb_tag)
                        model[i].wait1 = 1'b0;
                    if (model[i].wait2 && model[i].src2 == cdb_tag)
                        model[i].wait2 = 1'b0;
                    if (was_waiting && !model[i].wait1 && !model[i].wait2)
                        model[i].ready_cycle = cycle;
                end
            end

            if (branch_valid && branch_squash) begin
                for (int i = model.size() - 1; i >= 0; i--) begin
                    if (|(model[i].mask & branch_mask))
                        model.delete(i);   // squashed, must never issue
                end
            end else if (branch_valid) begin
                foreach (model[i]) begin
                    model[i].mask = model[i].mask & ~branch_mask;
                    model[i].payload[`MASK_BITS-1:0] =
                        model[i].payload[`MASK_BITS-1:0] & ~branch_mask;
                end
            end

            if (dispatch_valid) begin
                e.dest        = dispatch_dest;
                e.fu          = dispatch_fu;
                e.payload     = dispatch_payload;
                e.mask        = dispatch_mask;
                e.src1        = dispatch_src1;
                e.src2        = dispatch_src2;
                // same-cycle broadcast counts as delivered
                e.wait1       = dispatch_src1_used && !(cdb_valid && cdb_tag == dispatch_src1);
                e.wait2       = dispatch_src2_used && !(cdb_valid && cdb_tag == dispatch_src2);
                e.ready_cycle = (e.wait1 || e.wait2) ? not_ready : cycle;
                model.push_back(e);
            end
            cycle++;
        end
        pending = model.size();
    end

endmodule

// File: sim/rs_tb.sv
`timescale 1ns/100ps
`include "rs_settings.svh"

// table driven reservation station testbench
module rs_tb;

    typedef struct packed {
        logic            disp;
        core_pkg::tag_t  dest;
        core_pkg::tag_t  src1;
        logic            used1;
        core_pkg::tag_t  src2;
        logic            used2;
        core_pkg::fu_t   fu;
        core_pkg::mask_t mask;
        logic            cdb;
        core_pkg::tag_t  tag;
        logic            br;
        core_pkg::mask_t br_mask;
        logic            squash;
        logic            busy;    // alu_busy for the cycle
    } row_t;

    logic                     clock;
    logic                     reset;
    logic                     dispatch_valid;
    core_pkg::tag_t           dispatch_dest;
    core_pkg::tag_t           dispatch_src1;
    logic                     dispatch_src1_used;
    core_pkg::tag_t           dispatch_src2;
    logic                     dispatch_src2_used;
    core_pkg::fu_t            dispatch_fu;
    core_pkg::mask_t          dispatch_mask;
    logic [`PAYLOAD_BITS-1:0] dispatch_payload;
    logic                     cdb_valid;
    core_pkg::tag_t           cdb_tag;
    logic                     branch_valid;
    core_pkg::mask_t          branch_mask;
    logic                     branch_squash;
    logic                     alu_busy;
    logic                     issue_valid;
    core_pkg::fu_t            issue_fu;
    core_pkg::tag_t           issue_dest;
    logic [`PAYLOAD_BITS-1:0] issue_payload;
    logic                     full;
    logic                     empty;
    int                       pending;
    int                       errors;
    int                       busy_mult;
    row_t                     table_q[$];

    initial clock = 1'b0;
    always #10 clock = ~clock;   // 20 ns period

    rs_top i_rs_top (.*);

    rs_checker i_rs_checker (.*);

    // row fields as integers with fu 0 for alu and 1 for mult
    function automatic row_t make_row(int d, int dest, int s1, int u1, int s2, int u2, int fu,
                                      int m, int cv, int ctag, int bv, int bm, int bs, int b);
        row_t r;
        r.disp    = (d != 0);
        r.dest    = core_pkg::tag_t'(dest);
        r.src1    = core_pkg::tag_t'(s1);
        r.used1   = (u1 != 0);
        r.src2    = core_pkg::tag_t'(s2);
        r.used2   = (u2 != 0);
        r.fu      = (fu != 0) ? core_pkg::fu_mult : core_pkg::fu_alu;
        r.mask    = core_pkg::mask_t'(m);
        r.cdb     = (cv != 0);
        r.tag     = core_pkg::tag_t'(ctag);
        r.br      = (bv != 0);
        r.br_mask = core_pkg::mask_t'(bm);
        r.squash  = (bs != 0);
        r.busy    = (b != 0);
        return r;
    endfunction

    task automatic drive_row(input row_t r);
        logic [31:0] rnd;
        rnd                = $urandom();
        dispatch_valid     = r.disp;
        dispatch_dest      = r.dest;
        dispatch_src1      = r.src1;
        dispatch_src1_used = r.used1;
        dispatch_src2      = r.src2;
        dispatch_src2_used = r.used2;
        dispatch_fu        = r.fu;
        dispatch_mask      = r.mask;
        // low payload bits mirror the branch mask
        dispatch_payload   = r.disp ? {rnd[`PAYLOAD_BITS-1:`MASK_BITS], r.mask} : '0;
        cdb_valid          = r.cdb;
        cdb_tag            = r.tag;
        branch_valid       = r.br;
        branch_mask        = r.br_mask;
        branch_squash      = r.squash;
        alu_busy           = r.busy;
    endtask

    task automatic add_idle(input int n);
        repeat (n) table_q.push_back(make_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0));
    endtask

    initial begin
        int waited;
        int timeouts;
        int misc_fails;
        void'($urandom(37));
        timeouts   = 0;
        misc_fails = 0;
        reset      = 1'b1;
        drive_row(make_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0));

        // fill every slot with instructions waiting on tag 1
        table_q.push_back(make_row(1, 10, 1, 1, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0));
        table_q.push_back(make_row(1, 11, 1, 1, 0, 0, 1, 1, 0, 0, 0, 0, 0, 0));
        table_q.push_back(make_row(1, 12, 1, 1, 2, 1, 0, 2, 0, 0, 0, 0, 0, 0));
        table_q.push_back(make_row(1, 13, 1, 1, 0, 0, 1, 2, 0, 0, 0, 0, 0, 0));
        table_q.push_back(make_row(1, 14, 1, 1, 0, 0, 0, 4, 0, 0, 0, 0, 0, 0));
        table_q.push_back(make_row(1, 15, 1, 1, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0));
        table_q.push_back(make_row(1, 16, 1, 1, 3, 1, 0, 0, 0, 0, 0, 0, 0, 0));
        table_q.push_back(make_row(1, 17, 1, 1, 0, 0, 1, 4, 0, 0, 0, 0, 0, 0));
        add_idle(1);
        table_q.push_back(make_row(0, 0, 0, 0, 0, 0, 0, 0, 1, 2, 0, 0, 0, 0));  // wake src2 of 12
        table_q.push_back(make_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 2, 0, 0));  // resolve bit 1
        table_q.push_back(make_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 0));  // squash bit 0
        // wake the rest while the alu is held off
        table_q.push_back(make_row(0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 0, 0, 1));
        // two held cycles leave mult 17 waiting next to ready alu work
        repeat (2) table_q.push_back(make_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1));
        table_q.push_back(make_row(0, 0, 0, 0, 0, 0, 0, 0, 1, 3, 0, 0, 0, 0));
        add_idle(2);
        // mixed ready work for the alternation rule
        table_q.push_back(make_row(1, 20, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0));
        table_q.push_back(make_row(1, 21, 0, 0, 0, 0, 1, 0, 0, 0, 0, 0, 0, 0));
        table_q.push_back(make_row(1, 22, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0));
        table_q.push_back(make_row(1, 23, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0));
        table_q.push_back(make_row(1, 24, 5, 1, 0, 0, 1, 0, 1, 5, 0, 0, 0, 0));  // bypass
        table_q.push_back(make_row(1, 25, 6, 1, 0, 0, 0, 8, 0, 0, 0, 0, 0, 0));
        table_q.push_back(make_row(0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 8, 0, 0));  // resolve bit 3
        table_q.push_back(make_row(0, 0, 0, 0, 0, 0, 0, 0, 1, 6, 0, 0, 0, 0));
        add_idle(1);

        repeat (5) @(posedge clock);
        #2 reset = 1'b0;
        foreach (table_q[i]) begin
            @(posedge clock);
            #2 drive_row(table_q[i]);
        end

        waited = 0;
        while (pending != 0 && waited < 200) begin
            @(posedge clock);
            waited++;
        end
        if (pending != 0) begin
            $display("timeout: %0d instructions never issued", pending);
            timeouts++;
        end
        repeat (2) @(posedge clock);
        if (busy_mult == 0) begin
            $display("no multiplier instruction issued while alu_busy was high");
            misc_fails++;
        end

        $display("errors: %0d value, %0d timeout, %0d other", errors, timeouts, misc_fails);
        if (errors == 0 && timeouts == 0 && misc_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
